/* verilog/mul_pkg.sv */
package mul_pkg;

    // operand and product widths
    localparam int operand_width = 32;
    localparam int product_width = 64;

    // tag field widths
    localparam int phys_addr_width = 8;
    localparam int pc_width = 32;

    // one partial-product row per multiplier bit
    localparam int pp_rows = operand_width;

    // start to done, in cycles
    // pp stage, four compressor layers, final adder
    localparam int mul_latency = 6;

    // unsigned source operand
    typedef logic [operand_width-1:0] operand_t;

    // full product, also one partial-sum row
    typedef logic [product_width-1:0] product_t;

    // destination physical register
    typedef logic [phys_addr_width-1:0] phys_addr_t;

    // pc of the issuing instruction
    typedef logic [pc_width-1:0] pc_t;

endpackage

/* verilog/mul_rows_if.sv */
interface mul_rows_if
    import mul_pkg::*;
#(
    parameter int rows = 2
) ();

    // live operation in this stage, one cycle per op
    logic valid;

    // result tag travels with the rows
    phys_addr_t phys_addr;
    pc_t pc;

    // partial-sum rows, all product wide
    product_t row [rows];

    // producing stage
    modport src (
        output valid,
        output phys_addr,
        output pc,
        output row
    );

    // consuming stage, samples every edge
    modport dst (
        input valid,
        input phys_addr,
        input pc,
        input row
    );

endinterface

/* verilog/pp_gen_stage.sv */
module pp_gen_stage
    import mul_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input operand_t a,
    input operand_t b,
    input phys_addr_t phys_addr_in,
    input pc_t pc_in,
    mul_rows_if.src out
);

    logic valid_q;
    operand_t a_q;
    operand_t b_q;
    phys_addr_t phys_addr_q;
    pc_t pc_q;

    // multiplicand widened to row width
    product_t a_ext;

    // one cycle valid per accepted start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    // operands only load on start, hold otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
        end else if (start) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // tag captured alongside the operands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phys_addr_q <= '0;
            pc_q <= '0;
        end else if (start) begin
            phys_addr_q <= phys_addr_in;
            pc_q <= pc_in;
        end
    end

    assign a_ext = {{(product_width - operand_width){1'b0}}, a_q};

    assign out.valid = valid_q;
    assign out.phys_addr = phys_addr_q;
    assign out.pc = pc_q;

    // row i is a shifted by i, gated by bit i of b
    for (genvar i = 0; i < pp_rows; i++) begin : g_pp_row
        assign out.row[i] = b_q[i] ? (a_ext << i) : '0;
    end

endmodule

/* verilog/csa_reduce_stage.sv */
module csa_reduce_stage
    import mul_pkg::*;
#(
    parameter int in_rows = 32
) (
    input logic clk,
    input logic rst,
    mul_rows_if.dst in,
    mul_rows_if.src out
);

    localparam int out_rows = in_rows / 2;

    // each 4:2 compressor takes four rows, gives two
    localparam int groups = in_rows / 4;

    // compressed rows before the stage register
    product_t nxt_row [out_rows];

    // 3:2 sum bit, per column
    function automatic product_t csa_sum(
        input product_t x,
        input product_t y,
        input product_t z
    );
        return x ^ y ^ z;
    endfunction

    // 3:2 carry, already moved up one column
    function automatic product_t csa_carry(
        input product_t x,
        input product_t y,
        input product_t z
    );
        return ((x & y) | (y & z) | (x & z)) << 1;
    endfunction

    // two cascaded 3:2 layers per group of four
    // bits shifted past bit 63 drop out, result is mod 2^64
    always_comb begin
        product_t s1;
        product_t c1;
        for (int g = 0; g < groups; g++) begin
            s1 = csa_sum(in.row[4*g], in.row[4*g+1], in.row[4*g+2]);
            c1 = csa_carry(in.row[4*g], in.row[4*g+1], in.row[4*g+2]);
            nxt_row[2*g] = csa_sum(s1, c1, in.row[4*g+3]);
            nxt_row[2*g+1] = csa_carry(s1, c1, in.row[4*g+3]);
        end
    end

    // valid strobe moves one stage per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid;
        end
    end

    // tag follows the rows of the same op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.phys_addr <= '0;
            out.pc <= '0;
        end else begin
            out.phys_addr <= in.phys_addr;
            out.pc <= in.pc;
        end
    end

    // sum and carry rows registered every cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < out_rows; k++) begin
                out.row[k] <= '0;
            end
        end else begin
            for (int k = 0; k < out_rows; k++) begin
                out.row[k] <= nxt_row[k];
            end
        end
    end

endmodule

/* verilog/final_add_stage.sv */
module final_add_stage
    import mul_pkg::*;
(
    input logic clk,
    input logic rst,
    mul_rows_if.dst in,
    output product_t product,
    output logic done,
    output phys_addr_t phys_addr_out,
    output pc_t pc_out
);

    // carry-propagate sum of the last two rows
    product_t cpa_sum;

    assign cpa_sum = in.row[0] + in.row[1];

    // done pulses once per op, never sticky
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= in.valid;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            product <= '0;
        end else begin
            product <= cpa_sum;
        end
    end

    // tag registered with the product so both match in the done cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phys_addr_out <= '0;
            pc_out <= '0;
        end else begin
            phys_addr_out <= in.phys_addr;
            pc_out <= in.pc;
        end
    end

endmodule

/* verilog/pipelined_multiplier.sv */
module pipelined_multiplier
    import mul_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input operand_t a,
    input operand_t b,
    input phys_addr_t phys_addr_in,
    input pc_t pc_in,
    output product_t product,
    output logic done,
    output phys_addr_t phys_addr_out,
    output pc_t pc_out
);

    // row count halves at each compressor layer
    mul_rows_if #(.rows(pp_rows)) pp_if ();
    mul_rows_if #(.rows(pp_rows / 2)) l1_if ();
    mul_rows_if #(.rows(pp_rows / 4)) l2_if ();
    mul_rows_if #(.rows(pp_rows / 8)) l3_if ();
    mul_rows_if #(.rows(pp_rows / 16)) l4_if ();

    pp_gen_stage u_pp_gen_stage (
        .clk(clk),
        .rst(rst),
        .start(start),
        .a(a),
        .b(b),
        .phys_addr_in(phys_addr_in),
        .pc_in(pc_in),
        .out(pp_if.src)
    );

    // 32 -> 16
    csa_reduce_stage #(.in_rows(pp_rows)) u_csa_l1 (
        .clk(clk),
        .rst(rst),
        .in(pp_if.dst),
        .out(l1_if.src)
    );

    // 16 -> 8
    csa_reduce_stage #(.in_rows(pp_rows / 2)) u_csa_l2 (
        .clk(clk),
        .rst(rst),
        .in(l1_if.dst),
        .out(l2_if.src)
    );

    // 8 -> 4
    csa_reduce_stage #(.in_rows(pp_rows / 4)) u_csa_l3 (
        .clk(clk),
        .rst(rst),
        .in(l2_if.dst),
        .out(l3_if.src)
    );

    // 4 -> 2
    csa_reduce_stage #(.in_rows(pp_rows / 8)) u_csa_l4 (
        .clk(clk),
        .rst(rst),
        .in(l3_if.dst),
        .out(l4_if.src)
    );

    final_add_stage u_final_add_stage (
        .clk(clk),
        .rst(rst),
        .in(l4_if.dst),
        .product(product),
        .done(done),
        .phys_addr_out(phys_addr_out),
        .pc_out(pc_out)
    );

endmodule

/* dv/multiplier_properties.sv */
module multiplier_properties
    import mul_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int assert_fails = 0;

    // every sampled start completes after the fixed latency
    start_gives_done: assert property (
        @(posedge clk) disable iff (rst) start |-> ##mul_latency done
    ) else begin
        assert_fails++;
        $error("start was not followed by done after %0d cycles", mul_latency);
    end

    // no done without a matching start
    done_needs_start: assert property (
        @(posedge clk) disable iff (rst) done |-> $past(start, mul_latency)
    ) else begin
        assert_fails++;
        $error("done seen without a start %0d cycles earlier", mul_latency);
    end

    no_done_in_reset: assert property (
        @(posedge clk) rst |-> !done
    ) else begin
        assert_fails++;
        $error("done high while reset is asserted");
    end

endmodule

bind pipelined_multiplier multiplier_properties u_multiplier_properties (
    .clk(clk),
    .rst(rst),
    .start(start),
    .done(done)
);

/* dv/multiplier_tb.sv */
module multiplier_tb
    import mul_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_fixed = 10;
    localparam int num_random = 20;
    localparam int num_entries = num_fixed + num_random;

    typedef struct {
        operand_t a;
        operand_t b;
        phys_addr_t phys_addr;
        pc_t pc;
        int gap;
    } stim_t;

    typedef struct {
        int index;
        product_t product;
        phys_addr_t phys_addr;
        pc_t pc;
        int unsigned start_cycle;
    } expect_t;

    logic clk;
    logic rst;
    logic start;
    operand_t a;
    operand_t b;
    phys_addr_t phys_addr_in;
    pc_t pc_in;
    product_t product;
    logic done;
    phys_addr_t phys_addr_out;
    pc_t pc_out;

    stim_t stim [num_entries];
    expect_t exp_q [$];
    integer seed = 40811;
    int total_gap = 0;
    bit table_ready = 1'b0;
    int pass_count = 0;
    int fail_count = 0;
    int start_count = 0;
    int done_count = 0;
    int unsigned cycle = 0;

    pipelined_multiplier u_pipelined_multiplier (
        .clk(clk),
        .rst(rst),
        .start(start),
        .a(a),
        .b(b),
        .phys_addr_in(phys_addr_in),
        .pc_in(pc_in),
        .product(product),
        .done(done),
        .phys_addr_out(phys_addr_out),
        .pc_out(pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic stim_t make_entry(
        input operand_t ea,
        input operand_t eb,
        input phys_addr_t pa,
        input pc_t pc,
        input int gap
    );
        stim_t s;
        s.a = ea;
        s.b = eb;
        s.phys_addr = pa;
        s.pc = pc;
        s.gap = gap;
        return s;
    endfunction

    task automatic fill_table();
        // isolated corner cases first
        stim[0] = make_entry(32'h0000_0000, 32'hdead_beef, 8'h01, 32'h0000_1000, 8);
        stim[1] = make_entry(32'h1234_5678, 32'h0000_0000, 8'h02, 32'h0000_1004, 8);
        stim[2] = make_entry(32'h0000_0001, 32'hcafe_f00d, 8'h03, 32'h0000_1008, 8);
        stim[3] = make_entry(32'h89ab_cdef, 32'h0000_0001, 8'h04, 32'h0000_100c, 8);
        stim[4] = make_entry(32'hffff_ffff, 32'hffff_ffff, 8'hfe, 32'h8000_0010, 8);
        stim[5] = make_entry(32'h8000_0000, 32'h8000_0000, 8'h80, 32'hffff_fffc, 8);
        // back to back burst
        stim[6] = make_entry(32'hffff_ffff, 32'h0000_0002, 8'h10, 32'h0000_2000, 0);
        stim[7] = make_entry(32'h0001_0000, 32'h0001_0000, 8'h11, 32'h0000_2004, 0);
        stim[8] = make_entry(32'h7fff_ffff, 32'h7fff_ffff, 8'h12, 32'h0000_2008, 0);
        stim[9] = make_entry(32'h0000_0003, 32'h0000_0005, 8'h13, 32'h0000_200c, 8);
        for (int i = num_fixed; i < num_entries; i++) begin
            stim[i].a = operand_t'($random(seed));
            stim[i].b = operand_t'($random(seed));
            stim[i].phys_addr = phys_addr_t'($random(seed));
            stim[i].pc = pc_t'($random(seed));
            stim[i].gap = $unsigned($random(seed)) % 4;
        end
        for (int i = 0; i < num_entries; i++) begin
            total_gap += stim[i].gap;
        end
        table_ready = 1'b1;
    endtask

    task automatic drive_op(input int idx);
        expect_t e;
        start = 1'b1;
        a = stim[idx].a;
        b = stim[idx].b;
        phys_addr_in = stim[idx].phys_addr;
        pc_in = stim[idx].pc;
        e.index = idx;
        e.product = product_t'(stim[idx].a) * product_t'(stim[idx].b);
        e.phys_addr = stim[idx].phys_addr;
        e.pc = stim[idx].pc;
        // start is sampled at the next edge
        e.start_cycle = cycle + 1;
        exp_q.push_back(e);
        start_count++;
    endtask

    task automatic check_product(input string what, input product_t got, input product_t exp);
        if (got === exp) begin
            pass_count++;
            $display("[PASS] %s product = 0x%h", what, got);
        end else begin
            fail_count++;
            $display("[FAIL] %s product = 0x%h, expected 0x%h", what, got, exp);
        end
    endtask

    task automatic check_tag(
        input string what,
        input phys_addr_t got_addr,
        input pc_t got_pc,
        input phys_addr_t exp_addr,
        input pc_t exp_pc
    );
        if (got_addr === exp_addr && got_pc === exp_pc) begin
            pass_count++;
            $display("[PASS] %s phys_addr_out = 0x%h pc_out = 0x%h", what, got_addr, got_pc);
        end else begin
            fail_count++;
            $display("[FAIL] %s phys_addr_out = 0x%h expected 0x%h, pc_out = 0x%h expected 0x%h",
                     what, got_addr, exp_addr, got_pc, exp_pc);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        expect_t e;
        int unsigned lat;
        if (rst === 1'b0 && done === 1'b1) begin
            done_count++;
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("unexpected completion: done went high with no operation in flight");
            end else begin
                e = exp_q.pop_front();
                check_product($sformatf("op %0d", e.index), product, e.product);
                check_tag($sformatf("op %0d", e.index), phys_addr_out, pc_out, e.phys_addr, e.pc);
                // done seen here is sampled at the coming rising edge
                lat = cycle + 1 - e.start_cycle;
                if (lat == mul_latency) begin
                    pass_count++;
                    $display("[PASS] op %0d latency %0d cycles", e.index, mul_latency);
                end else begin
                    fail_count++;
                    $display("op %0d finished %0d cycles after its start instead of %0d",
                             e.index, lat, mul_latency);
                end
            end
        end
    end

    initial begin
        int limit_cycles;
        wait (table_ready && rst === 1'b0);
        limit_cycles = num_entries + total_gap + mul_latency + 20;
        #(limit_cycles * 20);
        $display("timeout: %0d results still missing after %0d cycles",
                 exp_q.size(), limit_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        int total_fail;
        rst = 1'b1;
        start = 1'b0;
        a = '0;
        b = '0;
        phys_addr_in = '0;
        pc_in = '0;
        fill_table();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle pipeline after reset
        repeat (4) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                fail_count++;
                $display("[FAIL] idle done = 0x%h, expected 0x0", done);
            end
            check_product("idle", product, '0);
        end

        for (int i = 0; i < num_entries; i++) begin
            @(posedge clk);
            #2;
            drive_op(i);
            repeat (stim[i].gap) begin
                @(posedge clk);
                #2;
                start = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        start = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // stray done pulses would show up here
        repeat (4) @(negedge clk);

        if (done_count != start_count) begin
            fail_count++;
            $display("saw %0d done pulses for %0d starts", done_count, start_count);
        end

        total_fail = fail_count + u_pipelined_multiplier.u_multiplier_properties.assert_fails;
        $display("checks passed: %0d, checks failed: %0d", pass_count, total_fail);
        if (total_fail == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/mul_pkg.sv
verilog/mul_rows_if.sv
verilog/pp_gen_stage.sv
verilog/csa_reduce_stage.sv
verilog/final_add_stage.sv
verilog/pipelined_multiplier.sv
dv/multiplier_properties.sv
dv/multiplier_tb.sv
